// File: hw/scanline_pkg.sv
/* widths, command address map, register indices and types shared by the
   scan-line DDR3 transfer address generator */
package scanline_pkg;

    localparam int ADDRESS_NUMBER    = 15;                 // ddr3 row address bits
    localparam int COLADDR_NUMBER    = 10;                 // ddr3 column address bits
    localparam int NUM_XFER_BITS     = 6;                  // transfer length, 0 stands for 64
    localparam int FRAME_WIDTH_BITS  = 13;                 // widths in 8-bursts
    localparam int FRAME_HEIGHT_BITS = 16;
    localparam int RC_BURST_BITS     = ADDRESS_NUMBER + COLADDR_NUMBER - 3; // {row, col8}
    localparam int PAR_MOD_LATENCY   = 7;                  // cycles until the pipeline settles

    localparam logic [15:0] SCANLINE_ADDR = 16'h120;      // command block base
    localparam logic [15:0] SCANLINE_MASK = 16'h3f0;

    typedef logic [RC_BURST_BITS-1:0]     row_col_t;      // burst address {row, col8}
    typedef logic [FRAME_WIDTH_BITS-1:0]  frame_x_t;
    typedef logic [FRAME_HEIGHT_BITS-1:0] frame_y_t;
    typedef logic [FRAME_WIDTH_BITS:0]    width_t;        // msb set when programmed as 0
    typedef logic [FRAME_HEIGHT_BITS:0]   height_t;
    typedef logic [NUM_XFER_BITS:0]       xfer_len_t;     // 1..64
    typedef logic [2:0]                   bank_t;
    typedef logic [ADDRESS_NUMBER-1:0]    row_t;
    typedef logic [COLADDR_NUMBER-4:0]    col8_t;         // column in 8-bursts
    typedef logic [31:0]                  cmd_data_t;
    typedef logic [3:0]                   reg_idx_t;

    localparam reg_idx_t REG_MODE         = 4'h0;         // {extra_pages, wr_mode, en, !rst}
    localparam reg_idx_t REG_START_ADDR   = 4'h2;
    localparam reg_idx_t REG_FULL_WIDTH   = 4'h3;         // line pitch per 8 lines
    localparam reg_idx_t REG_WINDOW_WH    = 4'h4;
    localparam reg_idx_t REG_WINDOW_X0Y0  = 4'h5;
    localparam reg_idx_t REG_WINDOW_START = 4'h6;

    typedef enum logic [2:0] {IDLE, ADDR_HI, DATA0, DATA1, DATA2, DATA3} cmd_state_t;

endpackage

// File: hw/scanline_cfg_if.sv
/* programmed window configuration, driven by the register block and read by
   the address pipeline and the transfer controller */
interface scanline_cfg_if;
    import scanline_pkg::*;

    row_col_t   start_addr;      // frame origin, bank 0
    width_t     full_width;      // row/col step per 8 lines
    width_t     window_width;
    height_t    window_height;
    frame_x_t   window_x0;
    frame_y_t   window_y0;
    frame_x_t   start_x;         // first transfer, window relative
    frame_y_t   start_y;
    logic       chn_en;          // new requests allowed
    logic       chn_rst;         // channel held in reset
    logic       wr_mode;         // 1 writes to memory
    logic [1:0] extra_pages;     // pages the client needs beyond one
    logic       param_write;     // pulse on any register write

    modport regs (output start_addr, full_width, window_width, window_height, window_x0,
                  window_y0, start_x, start_y, chn_en, chn_rst, wr_mode, extra_pages,
                  param_write);
    modport calc (input start_addr, full_width, window_width, window_height, window_x0,
                  window_y0, start_x, start_y, chn_rst, param_write);
    modport ctrl (input chn_en, chn_rst, wr_mode, extra_pages);

endinterface

// File: hw/scanline_cmd_deser.sv
/* byte-serial command receiver: address low/high then four data bytes,
   emits register index, data and a write pulse on an address match */
module scanline_cmd_deser (
    input  logic                    rst,        // clock
    input  logic                    mclk,       // async reset, active high
    input  logic [7:0]              cmd_ad,
    input  logic                    cmd_stb,    // marks the address low byte
    output scanline_pkg::reg_idx_t  reg_idx,
    output scanline_pkg::cmd_data_t cmd_data,
    output logic                    cmd_we
);
    import scanline_pkg::*;

    cmd_state_t  state;
    logic [15:0] addr_r;                        // {high, low} command address
    logic        addr_hit;

    assign addr_hit = (addr_r & SCANLINE_MASK) == (SCANLINE_ADDR & SCANLINE_MASK);
    assign reg_idx  = addr_r[3:0];              // register inside the block

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            state  <= IDLE;
            cmd_we <= 1'b0;
        end else begin
            cmd_we <= (state == DATA3) && addr_hit;    // data complete on the next cycle
            unique case (state)
                IDLE:    state <= cmd_stb ? ADDR_HI : IDLE;
                ADDR_HI: state <= DATA0;
                DATA0:   state <= DATA1;
                DATA1:   state <= DATA2;
                DATA2:   state <= DATA3;
                default: state <= IDLE;
            endcase
        end
    end

    // shift in from the top, so the first byte ends up least significant
    always_ff @(posedge rst) begin
        if ((state == IDLE && cmd_stb) || state == ADDR_HI)
            addr_r <= {cmd_ad, addr_r[15:8]};
        if (state inside {DATA0, DATA1, DATA2, DATA3})
            cmd_data <= {cmd_ad, cmd_data[31:8]};      // four shifts per command
    end

endmodule

// File: hw/scanline_regs.sv
/* programmed parameter registers; zero widths and heights decode to the
   maximum, the mode register yields enable, reset, direction and extra pages */
module scanline_regs (
    input  logic                    rst,        // clock
    input  logic                    mclk,       // async reset
    input  scanline_pkg::reg_idx_t  reg_idx,
    input  scanline_pkg::cmd_data_t cmd_data,
    input  logic                    cmd_we,
    scanline_cfg_if.regs            cfg
);
    import scanline_pkg::*;

    logic [4:0] mode_reg;                       // clears to disabled, in reset
    logic       lo_zero;                        // width field is 0, means maximum
    logic       hi_zero;                        // height field is 0

    assign lo_zero = ~|cmd_data[FRAME_WIDTH_BITS-1:0];
    assign hi_zero = ~|cmd_data[FRAME_HEIGHT_BITS+15:16];

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            mode_reg          <= '0;
            cfg.start_addr    <= '0;
            cfg.full_width    <= '0;
            cfg.window_width  <= '0;
            cfg.window_height <= '0;
            cfg.window_x0     <= '0;
            cfg.window_y0     <= '0;
            cfg.start_x       <= '0;
            cfg.start_y       <= '0;
        end else if (cmd_we) begin
            case (reg_idx)
                REG_MODE:       mode_reg       <= cmd_data[4:0];
                REG_START_ADDR: cfg.start_addr <= cmd_data[RC_BURST_BITS-1:0];
                REG_FULL_WIDTH: cfg.full_width <= {lo_zero, cmd_data[FRAME_WIDTH_BITS-1:0]};
                REG_WINDOW_WH: begin
                    cfg.window_width  <= {lo_zero, cmd_data[FRAME_WIDTH_BITS-1:0]};
                    cfg.window_height <= {hi_zero, cmd_data[FRAME_HEIGHT_BITS+15:16]};
                end
                REG_WINDOW_X0Y0: begin
                    cfg.window_x0 <= cmd_data[FRAME_WIDTH_BITS-1:0];
                    cfg.window_y0 <= cmd_data[FRAME_HEIGHT_BITS+15:16];
                end
                REG_WINDOW_START: begin
                    cfg.start_x <= cmd_data[FRAME_WIDTH_BITS-1:0];
                    cfg.start_y <= cmd_data[FRAME_HEIGHT_BITS+15:16];
                end
                default: ;                      // unused indices are ignored
            endcase
        end
    end

    assign cfg.chn_en      = &mode_reg[1:0];    // out of reset and enabled
    assign cfg.chn_rst     = ~mode_reg[0];
    assign cfg.wr_mode     = mode_reg[2];
    assign cfg.extra_pages = mode_reg[4:3];
    assign cfg.param_write = cmd_we;            // any write invalidates the pipeline

endmodule

// File: hw/scanline_addr_calc.sv
/* window position tracking and the registered pipeline that turns it into
   bank, row, column and transfer length, with a settle counter for validity */
module scanline_addr_calc (
    input  logic                                   rst,          // clock
    input  logic                                   mclk,         // async reset
    scanline_cfg_if.calc                           cfg,
    input  logic                                   frame_start,
    input  logic                                   xfer_start,
    output logic                                   calc_valid,
    output logic                                   last_in_row,
    output logic                                   last_block,
    input  logic                                   busy,
    output scanline_pkg::bank_t                    xfer_bank,
    output scanline_pkg::row_t                     xfer_row,
    output scanline_pkg::col8_t                    xfer_col,
    output logic [scanline_pkg::NUM_XFER_BITS-1:0] xfer_num128
);
    import scanline_pkg::*;

    frame_x_t                   curr_x;         // window relative start of next transfer
    frame_y_t                   curr_y;
    height_t                    next_y;
    frame_x_t                   frame_x;        // frame relative
    frame_y_t                   frame_y;
    width_t                     row_left;       // 8-bursts to the window right edge
    logic [COLADDR_NUMBER-3:0]  mem_page_left;  // 8-bursts to the ddr3 page end, 1..128
    xfer_len_t                  lim_by_xfer;    // row_left capped at 64
    xfer_len_t                  xfer_len;
    logic [FRAME_HEIGHT_BITS-4:0] frame_y8;     // line with the bank bits removed
    logic [FRAME_HEIGHT_BITS+FRAME_WIDTH_BITS-3:0] mul_full;
    row_col_t                   mul_rslt;
    row_col_t                   line_start;
    row_col_t                   row_col;
    logic [PAR_MOD_LATENCY-1:0] par_mod;        // fills with ones after a change
    logic                       last_in_row_w;
    logic                       last_row_w;

    assign mul_full      = frame_y8 * cfg.full_width;
    assign last_in_row_w = row_left == {{(FRAME_WIDTH_BITS-NUM_XFER_BITS){1'b0}}, xfer_len};
    assign last_row_w    = next_y == cfg.window_height;
    assign calc_valid    = par_mod[PAR_MOD_LATENCY-1];
    assign xfer_row      = row_col[RC_BURST_BITS-1:COLADDR_NUMBER-3];
    assign xfer_col      = row_col[COLADDR_NUMBER-4:0];
    assign xfer_num128   = xfer_len[NUM_XFER_BITS-1:0];   // 64 goes out as 0

    always_ff @(posedge rst) begin
        frame_x       <= curr_x + cfg.window_x0;
        frame_y       <= curr_y + cfg.window_y0;
        next_y        <= {1'b0, curr_y} + 1'b1;
        row_left      <= cfg.window_width - {1'b0, curr_x};
        mem_page_left <= 8'h80 - {1'b0, frame_x[COLADDR_NUMBER-4:0]};
        lim_by_xfer   <= (|row_left[FRAME_WIDTH_BITS:NUM_XFER_BITS]) ? xfer_len_t'(64)
                                                                    : row_left[NUM_XFER_BITS:0];
        xfer_len      <= (mem_page_left > {1'b0, lim_by_xfer}) ? lim_by_xfer
                                                              : mem_page_left[NUM_XFER_BITS:0];
        last_in_row   <= last_in_row_w;
        frame_y8      <= frame_y[FRAME_HEIGHT_BITS-1:3];
        xfer_bank     <= frame_y[2:0];          // consecutive lines rotate banks
        mul_rslt      <= mul_full[RC_BURST_BITS-1:0];
        line_start    <= cfg.start_addr + mul_rslt;
        row_col       <= line_start + {{(RC_BURST_BITS-FRAME_WIDTH_BITS){1'b0}}, frame_x};
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            par_mod    <= '0;
            curr_x     <= '0;
            curr_y     <= '0;
            last_block <= 1'b0;
        end else begin
            // frame_start reloads the position, so it restarts the pipeline too
            if (cfg.param_write || xfer_start || cfg.chn_rst || frame_start)
                par_mod <= '0;
            else
                par_mod <= {par_mod[PAR_MOD_LATENCY-2:0], 1'b1};

            if (cfg.chn_rst || frame_start)
                curr_x <= cfg.start_x;
            else if (xfer_start)
                curr_x <= last_in_row ? '0
                    : curr_x + {{(FRAME_WIDTH_BITS-NUM_XFER_BITS-1){1'b0}}, xfer_len};

            if (cfg.chn_rst || frame_start)
                curr_y <= cfg.start_y;
            else if (xfer_start && last_in_row)
                curr_y <= next_y[FRAME_HEIGHT_BITS-1:0];

            if (cfg.chn_rst || !busy)
                last_block <= 1'b0;
            else if (xfer_start && last_row_w && last_in_row)
                last_block <= 1'b1;             // final transfer of the window issued
        end
    end

endmodule

// File: hw/scanline_xfer_ctrl.sv
/* frame busy state, want/need requests to the sequencer, free-page and
   pending-transfer accounting, frame-done and page-reset pulses */
module scanline_xfer_ctrl (
    input  logic         rst,           // clock
    input  logic         mclk,          // async reset
    scanline_cfg_if.ctrl cfg,
    input  logic         frame_start,
    input  logic         next_page,     // client consumed or filled a buffer page
    input  logic         suspend,
    input  logic         xfer_grant,
    input  logic         xfer_done,
    input  logic         calc_valid,
    input  logic         last_block,
    output logic         busy,
    output logic         xfer_start,
    output logic         xfer_want,
    output logic         xfer_need,
    output logic         frame_done,
    output logic         xfer_reset_page
);

    logic [2:0] free_pages;             // buffer pages ready for a transfer, 0..4
    logic [1:0] pending;                // started but not yet done
    logic       pre_want;

    assign pre_want = cfg.chn_en && busy && !xfer_want && !xfer_start && calc_valid
                      && !last_block && !suspend;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            busy            <= 1'b0;
            xfer_start      <= 1'b0;
            xfer_want       <= 1'b0;
            xfer_need       <= 1'b0;
            free_pages      <= '0;
            pending         <= '0;
            frame_done      <= 1'b0;
            xfer_reset_page <= 1'b1;    // mode register comes out of reset disabled
        end else begin
            xfer_start      <= xfer_grant && !cfg.chn_rst;
            xfer_reset_page <= cfg.chn_rst;
            // the finishing transfer is the only one still counted
            frame_done      <= busy && last_block && xfer_done && (pending == 2'd1);

            if (cfg.chn_rst)
                busy <= 1'b0;
            else if (frame_start)
                busy <= 1'b1;
            else if (frame_done)
                busy <= 1'b0;

            if (cfg.chn_rst || xfer_grant)
                xfer_want <= 1'b0;
            else if (pre_want && (free_pages > {1'b0, cfg.extra_pages}))
                xfer_want <= 1'b1;

            if (cfg.chn_rst || xfer_grant)
                xfer_need <= 1'b0;
            else if (pre_want && (free_pages >= 3'd3))
                xfer_need <= 1'b1;      // buffer close to empty/full, urgent

            if (frame_start)
                free_pages <= cfg.wr_mode ? 3'd0 : 3'd4;    // writes wait for client data
            else if (xfer_start && !next_page)
                free_pages <= free_pages - 3'd1;
            else if (!xfer_start && next_page)
                free_pages <= free_pages + 3'd1;

            if (cfg.chn_rst || !busy)
                pending <= '0;
            else if (xfer_start && !xfer_done)
                pending <= pending + 2'd1;
            else if (!xfer_start && xfer_done)
                pending <= pending - 2'd1;
        end
    end

endmodule

// File: hw/mcntrl_scanline.sv
/* scan-line DDR3 transfer address generator for one channel; connects the
   command receiver, registers, address pipeline and transfer controller */
module mcntrl_scanline (
    input  logic                                   rst,          // clock
    input  logic                                   mclk,         // async reset, active high
    input  logic [7:0]                             cmd_ad,
    input  logic                                   cmd_stb,
    input  logic                                   frame_start,
    input  logic                                   next_page,
    input  logic                                   suspend,
    input  logic                                   xfer_grant,
    input  logic                                   xfer_done,
    output logic                                   frame_done,
    output logic                                   xfer_want,
    output logic                                   xfer_need,
    output logic                                   xfer_start,
    output scanline_pkg::bank_t                    xfer_bank,
    output scanline_pkg::row_t                     xfer_row,
    output scanline_pkg::col8_t                    xfer_col,
    output logic [scanline_pkg::NUM_XFER_BITS-1:0] xfer_num128,
    output logic                                   xfer_reset_page
);
    import scanline_pkg::*;

    reg_idx_t  reg_idx;
    cmd_data_t cmd_data;
    logic      cmd_we;
    logic      calc_valid;              // pipeline outputs settled
    logic      last_block;
    logic      busy;

    scanline_cfg_if cfg ();

    scanline_cmd_deser u_cmd_deser (
        .rst      (rst),
        .mclk     (mclk),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .reg_idx  (reg_idx),
        .cmd_data (cmd_data),
        .cmd_we   (cmd_we)
    );

    scanline_regs u_regs (
        .rst      (rst),
        .mclk     (mclk),
        .reg_idx  (reg_idx),
        .cmd_data (cmd_data),
        .cmd_we   (cmd_we),
        .cfg      (cfg.regs)
    );

    scanline_addr_calc u_addr_calc (
        .rst         (rst),
        .mclk        (mclk),
        .cfg         (cfg.calc),
        .frame_start (frame_start),
        .xfer_start  (xfer_start),
        .calc_valid  (calc_valid),
        .last_in_row (),                // used inside for the x wrap only
        .last_block  (last_block),
        .busy        (busy),
        .xfer_bank   (xfer_bank),
        .xfer_row    (xfer_row),
        .xfer_col    (xfer_col),
        .xfer_num128 (xfer_num128)
    );

    scanline_xfer_ctrl u_xfer_ctrl (
        .rst             (rst),
        .mclk            (mclk),
        .cfg             (cfg.ctrl),
        .frame_start     (frame_start),
        .next_page       (next_page),
        .suspend         (suspend),
        .xfer_grant      (xfer_grant),
        .xfer_done       (xfer_done),
        .calc_valid      (calc_valid),
        .last_block      (last_block),
        .busy            (busy),
        .xfer_start      (xfer_start),
        .xfer_want       (xfer_want),
        .xfer_need       (xfer_need),
        .frame_done      (frame_done),
        .xfer_reset_page (xfer_reset_page)
    );

endmodule

// File: verification/scanline_properties.sv
/* request/grant timing assertions, bound into the transfer address generator */
module scanline_properties (
    input logic rst,            // clock
    input logic mclk,           // async reset
    input logic xfer_grant,
    input logic xfer_start,
    input logic xfer_want,
    input logic frame_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // start is the grant delayed by exactly one cycle
    a_start_after_grant: assert property (@(posedge rst) disable iff (mclk)
        xfer_grant |=> xfer_start) else $error("xfer_start missing after grant");
    a_no_start_wo_grant: assert property (@(posedge rst) disable iff (mclk)
        !xfer_grant |=> !xfer_start) else $error("xfer_start without grant");
    a_want_drops: assert property (@(posedge rst) disable iff (mclk)
        xfer_grant |=> !xfer_want) else $error("xfer_want high after grant");
    a_done_pulse: assert property (@(posedge rst) disable iff (mclk)
        frame_done |=> !frame_done) else $error("frame_done longer than one cycle");

endmodule

bind mcntrl_scanline scanline_properties u_props (
    .rst        (rst),
    .mclk       (mclk),
    .xfer_grant (xfer_grant),
    .xfer_start (xfer_start),
    .xfer_want  (xfer_want),
    .frame_done (frame_done)
);

// File: verification/tb_mcntrl_scanline.sv
/* testbench for the scan-line address generator; programs it over the command
   bus from the input file, models sequencer and buffer, checks every transfer */
module tb_mcntrl_scanline;
    timeunit 1ns;
    timeprecision 1ps;
    import scanline_pkg::*;

    logic       rst = 1'b0;                      // clock
    logic       mclk;                            // async reset
    logic [7:0] cmd_ad;
    logic       cmd_stb, frame_start, suspend, xfer_grant, xfer_done;
    logic       next_page, page_auto, page_manual;
    logic       frame_done, xfer_want, xfer_need, xfer_start, xfer_reset_page;
    bank_t      xfer_bank;
    row_t       xfer_row;
    col8_t      xfer_col;
    logic [NUM_XFER_BITS-1:0] xfer_num128;
    logic       first_need;                      // expected xfer_need on the first grant

    byte        op_kind[$];                      // parsed file commands
    logic [31:0] op_a[$], op_b[$];
    logic [31:0] exp_bank[$], exp_row[$], exp_col[$], exp_num[$];
    int         wait_q[$];                       // cycles left until each xfer_done
    int         start_count, done_count, cycles, limit;

    assign next_page = page_auto | page_manual;

    mcntrl_scanline i_dut (
        .rst(rst), .mclk(mclk), .cmd_ad(cmd_ad), .cmd_stb(cmd_stb),
        .frame_start(frame_start), .next_page(next_page), .suspend(suspend),
        .xfer_grant(xfer_grant), .xfer_done(xfer_done), .frame_done(frame_done),
        .xfer_want(xfer_want), .xfer_need(xfer_need), .xfer_start(xfer_start),
        .xfer_bank(xfer_bank), .xfer_row(xfer_row), .xfer_col(xfer_col),
        .xfer_num128(xfer_num128), .xfer_reset_page(xfer_reset_page)
    );

    always #10 rst = ~rst;                       // 20 ns period

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    always @(posedge rst) begin
        cycles++;
        if (limit > 0 && cycles >= limit)
            stop_with_error("timeout: transfers did not complete");
    end

    // sequencer: grant one cycle after want, done 3..10 cycles after start
    initial begin : seq_model
        int i;
        void'($urandom(93533));
        forever begin
            @(posedge rst);
            #2;
            if (!mclk) begin
                xfer_grant = xfer_want && !xfer_grant;
                page_auto  = xfer_done;          // buffer page follows each done
                xfer_done  = 1'b0;
                for (i = 0; i < wait_q.size(); i++) begin
                    if (wait_q[i] > 0)
                        wait_q[i]--;
                end
                for (i = 0; i < wait_q.size(); i++) begin
                    if (wait_q[i] == 0) begin
                        xfer_done = 1'b1;        // one per cycle, others wait
                        wait_q.delete(i);
                        break;
                    end
                end
                if (xfer_start)
                    wait_q.push_back(3 + $urandom % 8);
            end
        end
    end

    // transfer fields are compared mid-cycle while xfer_start is high
    always @(negedge rst) begin
        if (!mclk) begin
            if (xfer_grant && start_count == 0)
                check_value("xfer_need", xfer_need, first_need);
            if (xfer_start) begin
                if (start_count >= exp_bank.size())
                    stop_with_error("more transfers than listed in the input file");
                check_value("xfer_bank", xfer_bank, exp_bank[start_count]);
                check_value("xfer_row", xfer_row, exp_row[start_count]);
                check_value("xfer_col", xfer_col, exp_col[start_count]);
                check_value("xfer_num128", xfer_num128, exp_num[start_count]);
                start_count++;
            end
            if (frame_done) begin
                if (wait_q.size() != 0)
                    stop_with_error("frame_done came before all transfers completed");
                done_count++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge rst);
        #2;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        next_cycle();
        cmd_ad  = addr[7:0];                     // low byte with strobe
        cmd_stb = 1'b1;
        next_cycle();
        cmd_stb = 1'b0;
        cmd_ad  = addr[15:8];
        for (int k = 0; k < 4; k++) begin
            next_cycle();
            cmd_ad = data[8*k +: 8];             // lsb first
        end
        next_cycle();
        cmd_ad = 8'h00;
        repeat (2) next_cycle();                 // write pulse, then register update
    endtask

    task automatic pulse_frame_start();
        start_count = 0;
        done_count  = 0;
        next_cycle();
        frame_start = 1'b1;
        next_cycle();
        frame_start = 1'b0;
    endtask

    task automatic pulse_page();
        page_manual = 1'b1;
        next_cycle();
        page_manual = 1'b0;
    endtask

    task automatic hold_want_low(input int n);
        repeat (n) begin
            next_cycle();
            check_value("xfer_want", xfer_want, 0);
            check_value("xfer_need", xfer_need, 0);
        end
    endtask

    task automatic finish_frame();
        while (done_count == 0) next_cycle();    // wait for the frame_done pulse
        repeat (15) next_cycle();
        check_value("frame_done count", done_count, 1);
        check_value("xfer_start count", start_count, exp_bank.size());
    endtask

    task automatic load_input();
        int    fd;
        string line;
        logic [31:0] a, b, c, d;
        fd = $fopen("verification/scanline_input.txt", "r");
        if (fd == 0) stop_with_error("cannot open the input file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 1 || line[0] == "#" || line[0] == "\n") continue;
            case (line[0])
                "t": begin
                    if ($sscanf(line, "t %h %h %h %h", a, b, c, d) != 4)
                        stop_with_error("bad transfer line in the input file");
                    exp_bank.push_back(a);
                    exp_row.push_back(b);
                    exp_col.push_back(c);
                    exp_num.push_back(d);
                end
                default: begin
                    a = 0;
                    b = 0;
                    void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
                    op_kind.push_back(line[0]);
                    op_a.push_back(a);
                    op_b.push_back(b);
                end
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        int frames;
        mclk = 1'b1;
        cmd_ad = 8'h00;
        cmd_stb = 1'b0;
        frame_start = 1'b0;
        suspend = 1'b0;
        xfer_grant = 1'b0;
        xfer_done = 1'b0;
        page_auto = 1'b0;
        page_manual = 1'b0;
        first_need = 1'b0;
        start_count = 0;
        done_count = 0;
        cycles = 0;
        limit = 0;
        frames = 0;
        load_input();
        foreach (op_kind[i]) if (op_kind[i] inside {"f", "p"}) frames++;
        limit = 200 * frames * exp_bank.size() + 500;
        repeat (8) @(posedge rst);
        #2 mclk = 1'b0;
        foreach (op_kind[i]) begin
            case (op_kind[i])
                "w": write_reg(op_a[i][15:0], op_b[i]);
                "f": begin                           // read frame, 4 free pages
                    first_need = 1'b1;               // urgent from the first request
                    write_reg(16'h120, op_a[i]);
                    pulse_frame_start();
                    finish_frame();
                end
                "d": begin                           // channel disabled and in reset
                    write_reg(16'h120, 32'h0);
                    check_value("xfer_reset_page", xfer_reset_page, 1);
                    pulse_frame_start();
                    hold_want_low(20);
                    check_value("xfer_reset_page", xfer_reset_page, 1);
                    check_value("xfer_start count", start_count, 0);
                end
                "p": begin                           // write frame waits for client pages
                    // one page more than extra_pages is free at the first request
                    first_need = (op_a[i][4:3] + 3'd1) >= 3'd3;
                    write_reg(16'h120, op_a[i]);
                    pulse_frame_start();
                    hold_want_low(20);
                    repeat (op_a[i][4:3]) pulse_page();
                    hold_want_low(20);
                    suspend = 1'b1;
                    pulse_page();                    // now enough pages, but suspended
                    hold_want_low(20);
                    suspend = 1'b0;
                    finish_frame();
                end
                default: stop_with_error("unknown command in the input file");
            endcase
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: verification/scanline_input.txt
# w <cmd addr> <data> register write | t <bank> <row> <col> <num128> expected transfer
# f <mode> read frame | d disable check | p <mode> write-mode frame with page/suspend checks
w 122 00001000
w 123 000000c8
w 124 00030064
w 125 00060064
w 126 00000000
t 6 0020 64 1c
t 6 0021 00 00
t 6 0021 40 08
t 7 0020 64 1c
t 7 0021 00 00
t 7 0021 40 08
t 0 0022 2c 1c
t 0 0022 48 00
t 0 0023 08 08
f 03
d
f 03
p 0f

// File: mcntrl_scanline.f
hw/scanline_pkg.sv
hw/scanline_cfg_if.sv
hw/scanline_cmd_deser.sv
hw/scanline_regs.sv
hw/scanline_addr_calc.sv
hw/scanline_xfer_ctrl.sv
hw/mcntrl_scanline.sv
verification/scanline_properties.sv
verification/tb_mcntrl_scanline.sv

// File: Makefile
all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f mcntrl_scanline.f \
		--top-module tb_mcntrl_scanline

run: build
	@out="$$(./obj_dir/Vtb_mcntrl_scanline 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "sim passed"

lint:
	verilator --lint-only --timing -f mcntrl_scanline.f --top-module tb_mcntrl_scanline

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
